/* design/ex_pkg.sv */
package ex_pkg;

  // Datapath widths
  localparam int word_w     = 32;
  localparam int reg_addr_w = 5;
  localparam int byte_en_w  = 4;

  typedef logic [word_w-1:0] word_t;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    COPY_B
  } aluop_t;

  // Bypass source for one operand
  typedef enum logic [1:0] {
    NONE,
    FWD_M,
    FWD_W
  } fwd_sel_t;

  typedef enum logic {
    A_RS1,
    A_IMM
  } alu_a_sel_t;

  typedef enum logic [1:0] {
    B_RS1,
    B_RS2,
    B_IMM
  } alu_b_sel_t;

  // Same encoding serves loads and stores
  typedef enum logic [2:0] {
    NONE_LT,
    LB,
    LBU,
    LH,
    LHU,
    LW
  } load_t;

  typedef enum logic [2:0] {
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU
  } branch_t;

  typedef struct packed {
    word_t                 pc;
    word_t                 pc4;
    word_t                 rs1_data;
    word_t                 rs2_data;
    word_t                 imm_a;
    word_t                 imm_b;
    alu_a_sel_t            alu_a_sel;
    alu_b_sel_t            alu_b_sel;
    aluop_t                aluop;
    logic [reg_addr_w-1:0] reg_rd;
    logic                  wen;
    logic                  dren;
    logic                  dwen;
    load_t                 load_type;
    logic                  branch_instr;
    branch_t               branch_type;
    word_t                 br_imm;
    logic                  jump_instr;
    logic                  j_sel;
    word_t                 j_offset;
    logic                  halt_instr;
  } decode_ex_t;

  typedef struct packed {
    fwd_sel_t sel_rs1;
    fwd_sel_t sel_rs2;
    word_t    data_mem;
    word_t    data_wb;
  } bypass_t;

  typedef struct packed {
    logic pc_en;
    logic flush;
    logic dmem_access;
    logic dmem_busy;
  } pipe_ctrl_t;

  typedef struct packed {
    logic                  wen;
    logic [reg_addr_w-1:0] reg_rd;
    word_t                 result;
    logic                  dren;
    logic                  dwen;
    word_t                 store_wdata;
    word_t                 memory_addr;
    logic [byte_en_w-1:0]  byte_en;
    load_t                 load_type;
    logic                  branch_instr;
    logic                  branch_taken;
    word_t                 resolved_addr;
    logic                  jump_instr;
    word_t                 jump_addr;
    word_t                 pc;
    logic                  halt_instr;
    // Valid entry loaded from execute
    logic                  token;
  } ex_mem_t;

endpackage

/* design/ex_operand_select.sv */
`timescale 1ns/1ns

module ex_operand_select (
  input  ex_pkg::decode_ex_t dec,
  input  ex_pkg::bypass_t    fwd,
  output ex_pkg::word_t      rs1_val,
  output ex_pkg::word_t      rs2_val,
  output ex_pkg::word_t      port_a,
  output ex_pkg::word_t      port_b
);

  // One bypass mux, used for both source registers
  function automatic ex_pkg::word_t bypass_mux(
    input ex_pkg::fwd_sel_t sel,
    input ex_pkg::word_t    reg_data,
    input ex_pkg::word_t    data_mem,
    input ex_pkg::word_t    data_wb
  );
    ex_pkg::word_t val;
    case (sel)
      ex_pkg::FWD_M: val = data_mem;
      ex_pkg::FWD_W: val = data_wb;
      default:       val = reg_data;
    endcase
    return val;
  endfunction

  assign rs1_val = bypass_mux(fwd.sel_rs1, dec.rs1_data, fwd.data_mem, fwd.data_wb);
  assign rs2_val = bypass_mux(fwd.sel_rs2, dec.rs2_data, fwd.data_mem, fwd.data_wb);

  assign port_a = (dec.alu_a_sel == ex_pkg::A_RS1) ? rs1_val : dec.imm_a;

  always_comb begin
    case (dec.alu_b_sel)
      ex_pkg::B_RS1: port_b = rs1_val;
      ex_pkg::B_RS2: port_b = rs2_val;
      default:       port_b = dec.imm_b;
    endcase
  end

endmodule

/* design/ex_alu.sv */
`timescale 1ns/1ns

module ex_alu (
  input  ex_pkg::word_t  port_a,
  input  ex_pkg::word_t  port_b,
  input  ex_pkg::aluop_t aluop,
  output ex_pkg::word_t  alu_out
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Only the low five bits count for RV32 shifts
  assign shamt = port_b[4:0];

  assign lt_signed   = $signed(port_a) < $signed(port_b);
  assign lt_unsigned = port_a < port_b;

  always_comb begin
    case (aluop)
      ex_pkg::ADD:    alu_out = port_a + port_b;
      ex_pkg::SUB:    alu_out = port_a - port_b;
      ex_pkg::AND:    alu_out = port_a & port_b;
      ex_pkg::OR:     alu_out = port_a | port_b;
      ex_pkg::XOR:    alu_out = port_a ^ port_b;
      ex_pkg::SLL:    alu_out = port_a << shamt;
      ex_pkg::SRL:    alu_out = port_a >> shamt;
      // Arithmetic shift keeps the sign bit
      ex_pkg::SRA:    alu_out = ex_pkg::word_t'($signed(port_a) >>> shamt);
      ex_pkg::SLT:    alu_out = ex_pkg::word_t'(lt_signed);
      ex_pkg::SLTU:   alu_out = ex_pkg::word_t'(lt_unsigned);
      // LUI style pass of the immediate
      ex_pkg::COPY_B: alu_out = port_b;
      default:        alu_out = '0;
    endcase
  end

endmodule

/* design/ex_branch_unit.sv */
`timescale 1ns/1ns

module ex_branch_unit (
  input  ex_pkg::decode_ex_t dec,
  input  ex_pkg::word_t      rs1_val,
  input  ex_pkg::word_t      rs2_val,
  output logic               branch_taken,
  output ex_pkg::word_t      resolved_addr,
  output ex_pkg::word_t      jump_addr
);

  logic          cond;
  ex_pkg::word_t branch_target;
  ex_pkg::word_t jump_base;
  ex_pkg::word_t jump_sum;

  // Compare on forwarded operands
  always_comb begin
    case (dec.branch_type)
      ex_pkg::BEQ:  cond = rs1_val == rs2_val;
      ex_pkg::BNE:  cond = rs1_val != rs2_val;
      ex_pkg::BLT:  cond = $signed(rs1_val) < $signed(rs2_val);
      ex_pkg::BGE:  cond = $signed(rs1_val) >= $signed(rs2_val);
      ex_pkg::BLTU: cond = rs1_val < rs2_val;
      ex_pkg::BGEU: cond = rs1_val >= rs2_val;
      default:      cond = 1'b0;
    endcase
  end

  assign branch_taken = dec.branch_instr & cond;

  assign branch_target = dec.pc + dec.br_imm;

  // Fall through to pc4 when not taken
  assign resolved_addr = branch_taken ? branch_target : dec.pc4;

  // JAL uses pc, JALR uses rs1
  assign jump_base = dec.j_sel ? dec.pc : rs1_val;
  assign jump_sum  = jump_base + dec.j_offset;

  assign jump_addr = {jump_sum[ex_pkg::word_w-1:1], 1'b0};

endmodule

/* design/ex_byte_enable.sv */
`timescale 1ns/1ns

module ex_byte_enable (
  input  ex_pkg::load_t                  load_type,
  input  logic [1:0]                     offset,
  output logic [ex_pkg::byte_en_w-1:0]   byte_en
);

  logic [ex_pkg::byte_en_w-1:0] byte_lane;
  logic [ex_pkg::byte_en_w-1:0] half_lanes;

  // Single lane selected by the offset
  assign byte_lane = ex_pkg::byte_en_w'(1) << offset;

  // Halfwords only on even offsets, misaligned gives no lanes
  assign half_lanes = offset[0] ? '0 : (ex_pkg::byte_en_w'(3) << offset);

  always_comb begin
    case (load_type)
      ex_pkg::LB,
      ex_pkg::LBU: byte_en = byte_lane;
      ex_pkg::LH,
      ex_pkg::LHU: byte_en = half_lanes;
      ex_pkg::LW:  byte_en = '1;
      default:     byte_en = '0;
    endcase
  end

endmodule

/* design/ex_mem_register.sv */
`timescale 1ns/1ns

module ex_mem_register (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               halt,
  input  ex_pkg::pipe_ctrl_t ctrl,
  input  ex_pkg::ex_mem_t    next_ex_mem,
  output ex_pkg::ex_mem_t    mem
);

  ex_pkg::ex_mem_t mem_next;
  logic            clear;
  logic            dmem_grant;

  // Halt or an accepted flush empties the stage
  assign clear = halt | (ctrl.flush & ctrl.pc_en);

  // Data memory finished, drop the request so it is not repeated
  assign dmem_grant = ctrl.dmem_access & ~ctrl.dmem_busy;

  always_comb begin
    mem_next = mem;
    if (clear) begin
      mem_next = '0;
    end else if (dmem_grant) begin
      mem_next.dren = 1'b0;
      mem_next.dwen = 1'b0;
    end else if (ctrl.pc_en) begin
      mem_next       = next_ex_mem;
      mem_next.token = 1'b1;
    end
    // Otherwise stall and keep the current entry
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      mem <= '0;
    end else begin
      mem <= mem_next;
    end
  end

endmodule

/* design/ex_stage.sv */
`timescale 1ns/1ns

module ex_stage (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               halt,
  input  ex_pkg::decode_ex_t dec,
  input  ex_pkg::bypass_t    fwd,
  input  ex_pkg::pipe_ctrl_t ctrl,
  output ex_pkg::ex_mem_t    mem
);

  ex_pkg::word_t                rs1_val;
  ex_pkg::word_t                rs2_val;
  ex_pkg::word_t                port_a;
  ex_pkg::word_t                port_b;
  ex_pkg::word_t                alu_out;
  ex_pkg::word_t                resolved_addr;
  ex_pkg::word_t                jump_addr;
  logic                         branch_taken;
  logic [ex_pkg::byte_en_w-1:0] byte_en;
  ex_pkg::ex_mem_t              next_ex_mem;

  ex_operand_select operand_i (
    .dec     (dec),
    .fwd     (fwd),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .port_a  (port_a),
    .port_b  (port_b)
  );

  ex_alu alu_i (
    .port_a  (port_a),
    .port_b  (port_b),
    .aluop   (dec.aluop),
    .alu_out (alu_out)
  );

  ex_branch_unit branch_i (
    .dec           (dec),
    .rs1_val       (rs1_val),
    .rs2_val       (rs2_val),
    .branch_taken  (branch_taken),
    .resolved_addr (resolved_addr),
    .jump_addr     (jump_addr)
  );

  // Byte lanes from the low address bits
  ex_byte_enable byte_en_i (
    .load_type (dec.load_type),
    .offset    (alu_out[1:0]),
    .byte_en   (byte_en)
  );

  always_comb begin
    next_ex_mem.wen           = dec.wen;
    next_ex_mem.reg_rd        = dec.reg_rd;
    next_ex_mem.result        = alu_out;
    next_ex_mem.dren          = dec.dren;
    next_ex_mem.dwen          = dec.dwen;
    next_ex_mem.store_wdata   = rs2_val;
    next_ex_mem.memory_addr   = alu_out;
    next_ex_mem.byte_en       = byte_en;
    next_ex_mem.load_type     = dec.load_type;
    next_ex_mem.branch_instr  = dec.branch_instr;
    next_ex_mem.branch_taken  = branch_taken;
    next_ex_mem.resolved_addr = resolved_addr;
    next_ex_mem.jump_instr    = dec.jump_instr;
    next_ex_mem.jump_addr     = jump_addr;
    next_ex_mem.pc            = dec.pc;
    next_ex_mem.halt_instr    = dec.halt_instr;
    // Token is set by the register when the entry loads
    next_ex_mem.token         = 1'b0;
  end

  ex_mem_register ex_mem_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .halt        (halt),
    .ctrl        (ctrl),
    .next_ex_mem (next_ex_mem),
    .mem         (mem)
  );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
  output logic CLK,
  output logic nRST
);

  // 40 ns period
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Reset held for four rising edges, released away from the edge
  initial begin
    nRST = 1'b0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

/* verif/ex_stage_checker.sv */
`timescale 1ns/1ns

module ex_stage_checker (
  input logic               CLK,
  input logic               nRST,
  input logic               halt,
  input ex_pkg::pipe_ctrl_t ctrl,
  input ex_pkg::ex_mem_t    mem
);

  int unsigned fail_count = 0;
  logic        stall;

  // Plain back-pressure, nothing clears or loads
  assign stall = !ctrl.pc_en && !ctrl.flush && !halt &&
                 !(ctrl.dmem_access && !ctrl.dmem_busy);

  a_halt_clears: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> (!mem.token && !mem.wen))
    else begin
      fail_count++;
      $error("halt left a valid entry in EX/MEM");
    end

  a_stall_holds: assert property (@(posedge CLK) disable iff (!nRST)
    stall |=> $stable(mem))
    else begin
      fail_count++;
      $error("EX/MEM changed during a stall");
    end

  // A single access is either a read or a write
  a_no_read_write: assert property (@(posedge CLK) disable iff (!nRST)
    !(mem.dren && mem.dwen))
    else begin
      fail_count++;
      $error("dren and dwen both high");
    end

endmodule

/* verif/ex_stage_tb.sv */
`timescale 1ns/1ns

module ex_stage_tb;

  logic               CLK;
  logic               nRST;
  logic               halt;
  ex_pkg::decode_ex_t dec;
  ex_pkg::bypass_t    fwd;
  ex_pkg::pipe_ctrl_t ctrl;
  ex_pkg::ex_mem_t    mem;

  ex_pkg::ex_mem_t exp_mem;
  int unsigned     errors;
  int unsigned     checks;
  logic            stim_done;

  tb_clock_gen clk_gen_i (
    .CLK  (CLK),
    .nRST (nRST)
  );

  ex_stage dut_i (
    .CLK  (CLK),
    .nRST (nRST),
    .halt (halt),
    .dec  (dec),
    .fwd  (fwd),
    .ctrl (ctrl),
    .mem  (mem)
  );

  bind ex_mem_register ex_stage_checker chk_i (
    .CLK  (CLK),
    .nRST (nRST),
    .halt (halt),
    .ctrl (ctrl),
    .mem  (mem)
  );

  function automatic ex_pkg::word_t rand_word();
    return $urandom();
  endfunction

  // True once in n draws
  function automatic logic chance(input int unsigned n);
    return $urandom_range(n - 1, 0) == 0;
  endfunction

  function automatic ex_pkg::decode_ex_t rand_decode();
    ex_pkg::decode_ex_t d;
    int unsigned        mode;
    d.pc        = rand_word() & 32'hffff_fffc;
    d.pc4       = d.pc + 32'd4;
    d.rs1_data  = rand_word();
    // Equal operands now and then so BEQ and BGE get hit
    d.rs2_data  = chance(4) ? d.rs1_data : rand_word();
    d.imm_a     = rand_word();
    d.imm_b     = rand_word();
    d.alu_a_sel = ex_pkg::alu_a_sel_t'(chance(2));
    d.alu_b_sel = ex_pkg::alu_b_sel_t'(2'($urandom_range(2, 0)));
    d.aluop     = ex_pkg::aluop_t'(4'($urandom_range(10, 0)));
    d.reg_rd    = 5'($urandom_range(31, 0));
    d.wen       = chance(2);
    mode        = $urandom_range(2, 0);
    d.dren      = (mode == 1);
    d.dwen      = (mode == 2);
    d.load_type = ex_pkg::load_t'(3'($urandom_range(5, 0)));
    d.branch_instr = chance(3);
    d.branch_type  = ex_pkg::branch_t'(3'($urandom_range(5, 0)));
    d.br_imm       = rand_word() & 32'hffff_fffe;
    d.jump_instr   = chance(3);
    d.j_sel        = chance(2);
    d.j_offset     = rand_word();
    d.halt_instr   = chance(16);
    return d;
  endfunction

  function automatic ex_pkg::bypass_t rand_bypass();
    ex_pkg::bypass_t f;
    f.sel_rs1  = ex_pkg::fwd_sel_t'(2'($urandom_range(2, 0)));
    f.sel_rs2  = ex_pkg::fwd_sel_t'(2'($urandom_range(2, 0)));
    f.data_mem = rand_word();
    f.data_wb  = rand_word();
    return f;
  endfunction

  function automatic ex_pkg::pipe_ctrl_t make_ctrl(input logic pc_en, input logic flush,
                                                   input logic access, input logic busy);
    ex_pkg::pipe_ctrl_t c;
    c.pc_en       = pc_en;
    c.flush       = flush;
    c.dmem_access = access;
    c.dmem_busy   = busy;
    return c;
  endfunction

  // Lane table by access type and offset
  function automatic logic [3:0] lanes_for(input ex_pkg::load_t lt, input logic [1:0] off);
    logic [3:0] lanes;
    lanes = 4'b0000;
    case (lt)
      ex_pkg::LB, ex_pkg::LBU: begin
        case (off)
          2'd0:    lanes = 4'b0001;
          2'd1:    lanes = 4'b0010;
          2'd2:    lanes = 4'b0100;
          default: lanes = 4'b1000;
        endcase
      end
      ex_pkg::LH, ex_pkg::LHU: begin
        if (off == 2'd0) lanes = 4'b0011;
        else if (off == 2'd2) lanes = 4'b1100;
      end
      ex_pkg::LW: lanes = 4'b1111;
      default: lanes = 4'b0000;
    endcase
    return lanes;
  endfunction

  // Expected EX/MEM contents after one rising edge
  function automatic ex_pkg::ex_mem_t model_ex_mem(input ex_pkg::decode_ex_t d,
                                                   input ex_pkg::bypass_t f,
                                                   input ex_pkg::pipe_ctrl_t c,
                                                   input logic h,
                                                   input ex_pkg::ex_mem_t prev);
    ex_pkg::word_t   a1;
    ex_pkg::word_t   a2;
    ex_pkg::word_t   pa;
    ex_pkg::word_t   pb;
    ex_pkg::word_t   alu;
    ex_pkg::word_t   jbase;
    logic [4:0]      sh;
    logic            cond;
    logic            take;
    ex_pkg::ex_mem_t n;
    a1 = (f.sel_rs1 == ex_pkg::FWD_M) ? f.data_mem :
         (f.sel_rs1 == ex_pkg::FWD_W) ? f.data_wb : d.rs1_data;
    a2 = (f.sel_rs2 == ex_pkg::FWD_M) ? f.data_mem :
         (f.sel_rs2 == ex_pkg::FWD_W) ? f.data_wb : d.rs2_data;
    pa = (d.alu_a_sel == ex_pkg::A_IMM) ? d.imm_a : a1;
    pb = (d.alu_b_sel == ex_pkg::B_RS1) ? a1 : (d.alu_b_sel == ex_pkg::B_RS2) ? a2 : d.imm_b;
    sh = pb[4:0];
    case (d.aluop)
      ex_pkg::ADD:    alu = pa + pb;
      ex_pkg::SUB:    alu = pa + ~pb + 32'd1;
      ex_pkg::AND:    alu = pa & pb;
      ex_pkg::OR:     alu = pa | pb;
      ex_pkg::XOR:    alu = pa ^ pb;
      ex_pkg::SLL:    alu = pa << sh;
      ex_pkg::SRL:    alu = pa >> sh;
      ex_pkg::SRA:    alu = (pa >> sh) | (pa[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      // Signed compare by flipping the sign bits
      ex_pkg::SLT:    alu = {31'b0, (pa ^ 32'h8000_0000) < (pb ^ 32'h8000_0000)};
      ex_pkg::SLTU:   alu = {31'b0, pa < pb};
      ex_pkg::COPY_B: alu = pb;
      default:        alu = 32'h0;
    endcase
    case (d.branch_type)
      ex_pkg::BEQ:  cond = (a1 == a2);
      ex_pkg::BNE:  cond = (a1 != a2);
      ex_pkg::BLT:  cond = (a1 ^ 32'h8000_0000) < (a2 ^ 32'h8000_0000);
      ex_pkg::BGE:  cond = !((a1 ^ 32'h8000_0000) < (a2 ^ 32'h8000_0000));
      ex_pkg::BLTU: cond = a1 < a2;
      ex_pkg::BGEU: cond = !(a1 < a2);
      default:      cond = 1'b0;
    endcase
    take  = d.branch_instr && cond;
    jbase = d.j_sel ? d.pc : a1;
    if (h || (c.flush && c.pc_en)) begin
      n = '0;
    end else if (c.dmem_access && !c.dmem_busy) begin
      n      = prev;
      n.dren = 1'b0;
      n.dwen = 1'b0;
    end else if (c.pc_en) begin
      n.wen           = d.wen;
      n.reg_rd        = d.reg_rd;
      n.result        = alu;
      n.dren          = d.dren;
      n.dwen          = d.dwen;
      n.store_wdata   = a2;
      n.memory_addr   = alu;
      n.byte_en       = lanes_for(d.load_type, alu[1:0]);
      n.load_type     = d.load_type;
      n.branch_instr  = d.branch_instr;
      n.branch_taken  = take;
      n.resolved_addr = take ? d.pc + d.br_imm : d.pc4;
      n.jump_instr    = d.jump_instr;
      n.jump_addr     = (jbase + d.j_offset) & 32'hffff_fffe;
      n.pc            = d.pc;
      n.halt_instr    = d.halt_instr;
      n.token         = 1'b1;
    end else begin
      n = prev;
    end
    return n;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_outputs();
    compare_value("wen", 32'(mem.wen), 32'(exp_mem.wen));
    compare_value("reg_rd", 32'(mem.reg_rd), 32'(exp_mem.reg_rd));
    compare_value("result", mem.result, exp_mem.result);
    compare_value("dren", 32'(mem.dren), 32'(exp_mem.dren));
    compare_value("dwen", 32'(mem.dwen), 32'(exp_mem.dwen));
    compare_value("store_wdata", mem.store_wdata, exp_mem.store_wdata);
    compare_value("memory_addr", mem.memory_addr, exp_mem.memory_addr);
    compare_value("byte_en", 32'(mem.byte_en), 32'(exp_mem.byte_en));
    compare_value("load_type", 32'(mem.load_type), 32'(exp_mem.load_type));
    compare_value("branch_instr", 32'(mem.branch_instr), 32'(exp_mem.branch_instr));
    compare_value("branch_taken", 32'(mem.branch_taken), 32'(exp_mem.branch_taken));
    compare_value("resolved_addr", mem.resolved_addr, exp_mem.resolved_addr);
    compare_value("jump_instr", 32'(mem.jump_instr), 32'(exp_mem.jump_instr));
    compare_value("jump_addr", mem.jump_addr, exp_mem.jump_addr);
    compare_value("pc", mem.pc, exp_mem.pc);
    compare_value("halt_instr", 32'(mem.halt_instr), 32'(exp_mem.halt_instr));
    compare_value("token", 32'(mem.token), 32'(exp_mem.token));
  endtask

  task automatic apply_inputs(input ex_pkg::decode_ex_t d, input ex_pkg::bypass_t f,
                              input ex_pkg::pipe_ctrl_t c, input logic h);
    @(posedge CLK);
    dec  <= d;
    fwd  <= f;
    ctrl <= c;
    halt <= h;
  endtask

  task automatic wait_reset_release(input string who);
    int n;
    n = 0;
    while (nRST !== 1'b1 && n < 20) begin
      @(posedge CLK);
      n++;
    end
    if (nRST !== 1'b1) begin
      errors++;
      $display("Timeout in %s: reset was never released", who);
    end
  endtask

  task automatic finish_run();
    errors += dut_i.ex_mem_i.chk_i.fail_count;
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  // Stimulus
  initial begin
    ex_pkg::decode_ex_t d;
    int                 lt;
    int                 off;
    void'($urandom(32'h289f));
    halt      = 1'b0;
    dec       = '0;
    fwd       = '0;
    ctrl      = '0;
    stim_done = 1'b0;
    wait_reset_release("stimulus");
    // Nothing may load while pc_en stays low
    repeat (8) apply_inputs(rand_decode(), rand_bypass(),
                            make_ctrl(1'b0, chance(2), chance(2), chance(2)), chance(4));
    repeat (40) apply_inputs(rand_decode(), rand_bypass(),
                             make_ctrl(1'b1, 1'b0, 1'b0, 1'b0), 1'b0);
    // Every access type at every offset
    for (lt = 0; lt < 6; lt++) begin
      for (off = 0; off < 4; off++) begin
        d           = rand_decode();
        d.aluop     = ex_pkg::COPY_B;
        d.alu_b_sel = ex_pkg::B_IMM;
        d.imm_b     = (rand_word() & 32'hffff_fffc) | 32'(off);
        d.load_type = ex_pkg::load_t'(3'(lt));
        apply_inputs(d, rand_bypass(), make_ctrl(1'b1, 1'b0, 1'b0, 1'b0), 1'b0);
      end
    end
    repeat (30) begin
      d              = rand_decode();
      d.branch_instr = !chance(4);
      d.jump_instr   = chance(2);
      apply_inputs(d, rand_bypass(), make_ctrl(1'b1, 1'b0, 1'b0, 1'b0), 1'b0);
    end
    // Mixed stall, flush, halt and dmem arbitration
    repeat (60) apply_inputs(rand_decode(), rand_bypass(),
                             make_ctrl(!chance(3), chance(6), chance(3), chance(2)), chance(12));
    // Load then store, each held while busy and dropped on grant
    for (lt = 0; lt < 2; lt++) begin
      d      = rand_decode();
      d.dren = (lt == 0);
      d.dwen = (lt == 1);
      apply_inputs(d, rand_bypass(), make_ctrl(1'b1, 1'b0, 1'b0, 1'b0), 1'b0);
      apply_inputs(rand_decode(), rand_bypass(), make_ctrl(1'b0, 1'b0, 1'b1, 1'b1), 1'b0);
      apply_inputs(rand_decode(), rand_bypass(), make_ctrl(1'b0, 1'b0, 1'b1, 1'b0), 1'b0);
    end
    apply_inputs(rand_decode(), rand_bypass(), make_ctrl(1'b0, 1'b0, 1'b0, 1'b0), 1'b0);
    @(posedge CLK);
    stim_done = 1'b1;
  end

  // Model at the rising edge, compare at the falling edge
  initial begin
    int unsigned cycles;
    errors  = 0;
    checks  = 0;
    exp_mem = '0;
    wait_reset_release("compare");
    cycles = 0;
    while (!stim_done && cycles < 2000) begin
      @(posedge CLK);
      exp_mem = model_ex_mem(dec, fwd, ctrl, halt, exp_mem);
      @(negedge CLK);
      check_outputs();
      cycles++;
    end
    if (!stim_done) begin
      errors++;
      $display("Timeout: stimulus did not finish within %0d cycles", cycles);
    end
    finish_run();
  end

endmodule

/* ex_stage.f */
design/ex_pkg.sv
design/ex_operand_select.sv
design/ex_alu.sv
design/ex_branch_unit.sv
design/ex_byte_enable.sv
design/ex_mem_register.sv
design/ex_stage.sv
verif/tb_clock_gen.sv
verif/ex_stage_checker.sv
verif/ex_stage_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := ex_stage_tb
FILELIST  := ex_stage.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed
FAIL_MSG  := Some tests failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
